//--- common/conv_pkg.sv
`default_nettype none

package conv_pkg;

	// Stream and image sizes
	localparam int PIXEL_WIDTH = 8;
	localparam int WEIGHT_WIDTH = 8;
	localparam int SUM_WIDTH = 20;
	localparam int KERNEL_DIM = 3;
	localparam int KERNEL_SIZE = KERNEL_DIM * KERNEL_DIM;
	localparam int IMG_WIDTH = 8;
	localparam int IMG_HEIGHT = 6;
	localparam int KFIFO_DEPTH = 4;

	// Counter widths and terminal values
	localparam int POS_WIDTH = 3;
	localparam int TAP_CNT_WIDTH = 4;
	localparam int KFIFO_PTR_WIDTH = $clog2(KFIFO_DEPTH);
	localparam logic [POS_WIDTH-1:0] LAST_COL = POS_WIDTH'(IMG_WIDTH - 1);
	localparam logic [POS_WIDTH-1:0] LAST_ROW = POS_WIDTH'(IMG_HEIGHT - 1);
	localparam logic [TAP_CNT_WIDTH-1:0] LAST_TAP = TAP_CNT_WIDTH'(KERNEL_SIZE - 1);
	localparam logic [KFIFO_PTR_WIDTH:0] KFIFO_FULL_COUNT = (KFIFO_PTR_WIDTH + 1)'(KFIFO_DEPTH);

	////////////////////////////////////////
	// Kernel taps, row-major, w0 top-left
	typedef struct packed {
		logic signed [WEIGHT_WIDTH-1:0] w0;
		logic signed [WEIGHT_WIDTH-1:0] w1;
		logic signed [WEIGHT_WIDTH-1:0] w2;
		logic signed [WEIGHT_WIDTH-1:0] w3;
		logic signed [WEIGHT_WIDTH-1:0] w4;
		logic signed [WEIGHT_WIDTH-1:0] w5;
		logic signed [WEIGHT_WIDTH-1:0] w6;
		logic signed [WEIGHT_WIDTH-1:0] w7;
		logic signed [WEIGHT_WIDTH-1:0] w8;
	} kernel_t;

	// Neighbourhood in the same order as the taps
	typedef struct packed {
		logic [PIXEL_WIDTH-1:0] p0;
		logic [PIXEL_WIDTH-1:0] p1;
		logic [PIXEL_WIDTH-1:0] p2;
		logic [PIXEL_WIDTH-1:0] p3;
		logic [PIXEL_WIDTH-1:0] p4;
		logic [PIXEL_WIDTH-1:0] p5;
		logic [PIXEL_WIDTH-1:0] p6;
		logic [PIXEL_WIDTH-1:0] p7;
		logic [PIXEL_WIDTH-1:0] p8;
	} window_t;

	// Row and col locate the window centre
	typedef struct packed {
		logic signed [SUM_WIDTH-1:0] sum;
		logic [POS_WIDTH-1:0] row;
		logic [POS_WIDTH-1:0] col;
	} result_t;

endpackage

`default_nettype wire

//--- files.f
common/conv_pkg.sv
weight_buffer/kernel_fifo.sv
weight_buffer/weight_buffer.sv
window/line_window.sv
verilog/conv_mac.sv
verilog/conv_3x3_top.sv
tests/tb_conv_3x3.sv

//--- tests/conv_input.txt
# Tags: T name, I, W w0..w8, Q, L, K full, P gap p0..p7, R gap, E row sum_col1..sum_col6
# Q raises load_req early, R resends the stored frame with gap idle cycles per pixel
T after_reset
I
T first_load
Q
W 1 2 3 0 -1 4 -2 5 1
L
T frame_kernel_a
E 1 132 145 158 171 184 197
E 2 262 275 288 301 314 327
E 3 392 405 418 431 444 457
E 4 522 535 548 561 574 587
P 0 0 1 2 3 4 5 6 7
P 0 10 11 12 13 14 15 16 17
P 0 20 21 22 23 24 25 26 27
P 0 30 31 32 33 34 35 36 37
P 0 40 41 42 43 44 45 46 47
P 0 50 51 52 53 54 55 56 57
T queue_fill
W -3 0 2 1 -5 0 4 -1 -2
W -7 0 0 0 0 0 0 0 0
W 1 1 1 1 1 1 1 1 1
K 0
W -1 -1 -1 -1 -1 -1 -1 -1 -1
K 1
L
K 0
T frame_kernel_b
E 1 -26 -30 -34 -38 -42 -46
E 2 -66 -70 -74 -78 -82 -86
E 3 -106 -110 -114 -118 -122 -126
E 4 -146 -150 -154 -158 -162 -166
R 0
T frame_kernel_c
L
E 1 0 -7 -14 -21 -28 -35
E 2 -70 -77 -84 -91 -98 -105
E 3 -140 -147 -154 -161 -168 -175
E 4 -210 -217 -224 -231 -238 -245
R 0
T pixel_gaps
L
E 1 99 108 117 126 135 144
E 2 189 198 207 216 225 234
E 3 279 288 297 306 315 324
E 4 369 378 387 396 405 414
R 2

//--- tests/tb_conv_3x3.sv
`timescale 1ns/100ps
`default_nettype none

module tb_conv_3x3;

	localparam int ACK_TIMEOUT = 50;
	localparam int DRAIN_TIMEOUT = 200;

	logic clk = 1'b0;
	logic reset;
	logic weight_valid;
	logic signed [conv_pkg::WEIGHT_WIDTH-1:0] weight_in;
	logic load_req;
	logic load_ack;
	logic kernel_ready;
	logic kernel_full;
	logic pixel_valid;
	logic [conv_pkg::PIXEL_WIDTH-1:0] pixel_in;
	logic result_valid;
	conv_pkg::result_t result;

	conv_pkg::result_t exp_q [$];
	int due_q [$];
	int img [conv_pkg::IMG_HEIGHT][conv_pkg::IMG_WIDTH];
	int cyc = 0;
	int pix_row = 0;
	int pix_col = 0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	logic [8*32-1:0] test_name;

	conv_3x3_top conv_3x3_top_i (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_in    (weight_in),
		.load_req     (load_req),
		.load_ack     (load_ack),
		.kernel_ready (kernel_ready),
		.kernel_full  (kernel_full),
		.pixel_valid  (pixel_valid),
		.pixel_in     (pixel_in),
		.result_valid (result_valid),
		.result       (result)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic void count_failure();
		test_errors++;
		total_errors++;
	endfunction

	////////////////////////////////////////
	// Result monitor, falling edge

	always @(negedge clk) begin : monitor
		conv_pkg::result_t want;
		int due;
		if (result_valid) begin
			assert (exp_q.size() > 0 && due_q.size() > 0) else begin
				$display("Result for row %0d col %0d arrived when none was expected",
					result.row, result.col);
				count_failure();
			end
			if (exp_q.size() > 0 && due_q.size() > 0) begin
				want = exp_q.pop_front();
				due = due_q.pop_front();
				assert (result == want) else begin
					$display("ERR %0t: expected sum %0d row %0d col %0d, got sum %0d row %0d col %0d",
						$time, want.sum, want.row, want.col, result.sum, result.row, result.col);
					count_failure();
				end
				assert (cyc == due) else begin
					$display("ERR %0t: result for row %0d col %0d in cycle %0d, expected cycle %0d",
						$time, want.row, want.col, cyc, due);
					count_failure();
				end
			end
		end
	end

	////////////////////////////////////////
	// Driver tasks

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycle();
		next_cycle();
		pixel_valid = 1'b0;
		weight_valid = 1'b0;
	endtask

	task automatic send_weight(input int value);
		next_cycle();
		assert (load_ack == 1'b0) else begin
			$display("ERR %0t: load_ack high before the kernel set was complete", $time);
			count_failure();
		end
		weight_valid = 1'b1;
		weight_in = value[conv_pkg::WEIGHT_WIDTH-1:0];
	endtask

	task automatic send_pixel(input int value, input int gap);
		next_cycle();
		pixel_valid = 1'b1;
		pixel_in = value[conv_pkg::PIXEL_WIDTH-1:0];
		// Window completes here, its result is due 4 cycles on
		if (pix_row >= 2 && pix_col >= 2) begin
			due_q.push_back(cyc + 4);
		end
		if (pix_col == conv_pkg::IMG_WIDTH - 1) begin
			pix_col = 0;
			pix_row = (pix_row == conv_pkg::IMG_HEIGHT - 1) ? 0 : pix_row + 1;
		end else begin
			pix_col++;
		end
		repeat (gap) begin
			next_cycle();
			pixel_valid = 1'b0;
		end
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (load_ack !== level && n < ACK_TIMEOUT) begin
			next_cycle();
			n++;
		end
		assert (load_ack === level) else begin
			$display("Timed out waiting for load_ack to go %0s", level ? "high" : "low");
			count_failure();
		end
	endtask

	// Request before any set is queued, no ack may come back
	task automatic request_early();
		next_cycle();
		load_req = 1'b1;
		repeat (4) begin
			next_cycle();
			assert (load_ack == 1'b0) else begin
				$display("ERR %0t: load_ack high with no kernel set queued", $time);
				count_failure();
			end
		end
	endtask

	task automatic load_kernel();
		next_cycle();
		load_req = 1'b1;
		wait_ack(1'b1);
		assert (kernel_ready == 1'b1) else begin
			$display("ERR %0t: kernel_ready low after load_ack", $time);
			count_failure();
		end
		next_cycle();
		load_req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic check_idle();
		assert (!load_ack && !kernel_ready && !kernel_full && !result_valid) else begin
			$display("ERR %0t: after reset ack %b ready %b full %b result_valid %b",
				$time, load_ack, kernel_ready, kernel_full, result_valid);
			count_failure();
		end
	endtask

	task automatic finish_test();
		int n;
		n = 0;
		while ((exp_q.size() > 0 || due_q.size() > 0) && n < DRAIN_TIMEOUT) begin
			next_cycle();
			n++;
		end
		assert (exp_q.size() == 0 && due_q.size() == 0) else begin
			$display("Timed out with %0d expected results never seen", exp_q.size());
			count_failure();
			exp_q.delete();
			due_q.delete();
		end
		if (test_errors == 0) begin
			tests_passed++;
			$display("Test %0s passed", test_name);
		end else begin
			tests_failed++;
			$display("Test %0s failed with %0d errors", test_name, test_errors);
		end
		test_errors = 0;
	endtask

	////////////////////////////////////////
	// Record reader

	initial begin : stimulus
		int fd;
		int rc;
		int val;
		int gap;
		int row;
		int col;
		bit in_test;
		logic [8*32-1:0] tag;
		logic [8*128-1:0] line_buf;
		conv_pkg::result_t want;

		reset = 1'b1;
		weight_valid = 1'b0;
		weight_in = '0;
		load_req = 1'b0;
		pixel_valid = 1'b0;
		pixel_in = '0;
		in_test = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		fd = $fopen("tests/conv_input.txt", "r");
		assert (fd != 0) else begin
			$display("Could not open tests/conv_input.txt");
			count_failure();
		end
		if (fd != 0) begin
			while ($fscanf(fd, " %s", tag) == 1) begin
				case (tag)
					"#": rc = $fgets(line_buf, fd);
					"T": begin
						if (in_test) begin
							finish_test();
						end
						rc = $fscanf(fd, " %s", test_name);
						in_test = 1'b1;
					end
					"I": check_idle();
					"Q": request_early();
					"L": load_kernel();
					"W": begin
						repeat (conv_pkg::KERNEL_SIZE) begin
							rc = $fscanf(fd, "%d", val);
							send_weight(val);
						end
						idle_cycle();
					end
					"K": begin
						rc = $fscanf(fd, "%d", val);
						next_cycle();
						assert (kernel_full == val[0]) else begin
							$display("ERR %0t: kernel_full expected %0d, got %b",
								$time, val, kernel_full);
							count_failure();
						end
					end
					"P": begin
						rc = $fscanf(fd, "%d", gap);
						row = pix_row;
						for (col = 0; col < conv_pkg::IMG_WIDTH; col++) begin
							rc = $fscanf(fd, "%d", val);
							img[row][col] = val;
							send_pixel(val, gap);
						end
						idle_cycle();
					end
					"R": begin
						rc = $fscanf(fd, "%d", gap);
						for (row = 0; row < conv_pkg::IMG_HEIGHT; row++) begin
							for (col = 0; col < conv_pkg::IMG_WIDTH; col++) begin
								send_pixel(img[row][col], gap);
							end
						end
						idle_cycle();
					end
					// One row of window centres, columns 1 to 6
					"E": begin
						rc = $fscanf(fd, "%d", row);
						for (col = 1; col <= conv_pkg::IMG_WIDTH - 2; col++) begin
							rc = $fscanf(fd, "%d", val);
							want.sum = val[conv_pkg::SUM_WIDTH-1:0];
							want.row = row[conv_pkg::POS_WIDTH-1:0];
							want.col = col[conv_pkg::POS_WIDTH-1:0];
							exp_q.push_back(want);
						end
					end
					default: begin
						$display("Unknown record %0s in the input file", tag);
						count_failure();
						rc = $fgets(line_buf, fd);
					end
				endcase
			end
			$fclose(fd);
		end
		if (in_test) begin
			finish_test();
		end

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (total_errors == 0 && tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/conv_3x3_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv_3x3_top (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     weight_valid,
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0] weight_in,
	input  logic                                     load_req,
	output logic                                     load_ack,
	output logic                                     kernel_ready,
	output logic                                     kernel_full,
	input  logic                                     pixel_valid,
	input  logic [conv_pkg::PIXEL_WIDTH-1:0]         pixel_in,
	output logic                                     result_valid,
	output conv_pkg::result_t                        result
);

	conv_pkg::kernel_t kernel;
	conv_pkg::window_t window;
	logic window_valid;
	logic [conv_pkg::POS_WIDTH-1:0] win_row;
	logic [conv_pkg::POS_WIDTH-1:0] win_col;

	// Kernel queue and active kernel
	weight_buffer weight_buffer_i (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight_in    (weight_in),
		.load_req     (load_req),
		.load_ack     (load_ack),
		.kernel       (kernel),
		.kernel_ready (kernel_ready),
		.kernel_full  (kernel_full)
	);

	// 3x3 neighbourhood from the pixel stream
	line_window line_window_i (
		.clk          (clk),
		.reset        (reset),
		.pixel_valid  (pixel_valid),
		.pixel_in     (pixel_in),
		.window_valid (window_valid),
		.window       (window),
		.win_row      (win_row),
		.win_col      (win_col)
	);

	conv_mac conv_mac_i (
		.clk          (clk),
		.reset        (reset),
		.window_valid (window_valid),
		.window       (window),
		.win_row      (win_row),
		.win_col      (win_col),
		.kernel       (kernel),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

`default_nettype wire

//--- verilog/conv_mac.sv
`timescale 1ns/100ps
`default_nettype none

module conv_mac (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           window_valid,
	input  conv_pkg::window_t              window,
	input  logic [conv_pkg::POS_WIDTH-1:0] win_row,
	input  logic [conv_pkg::POS_WIDTH-1:0] win_col,
	input  conv_pkg::kernel_t              kernel,
	output logic                           result_valid,
	output conv_pkg::result_t              result
);

	logic [conv_pkg::KERNEL_SIZE-1:0][conv_pkg::PIXEL_WIDTH-1:0] pix;
	logic [conv_pkg::KERNEL_SIZE-1:0][conv_pkg::WEIGHT_WIDTH-1:0] wt;
	logic signed [conv_pkg::SUM_WIDTH-1:0] prod [conv_pkg::KERNEL_SIZE];
	logic signed [conv_pkg::SUM_WIDTH-1:0] row_sum [conv_pkg::KERNEL_DIM];
	logic valid_s1;
	logic valid_s2;
	logic [conv_pkg::POS_WIDTH-1:0] row_s1;
	logic [conv_pkg::POS_WIDTH-1:0] col_s1;
	logic [conv_pkg::POS_WIDTH-1:0] row_s2;
	logic [conv_pkg::POS_WIDTH-1:0] col_s2;

	// Flat views with tap 0 at the top index of both
	assign pix = window;
	assign wt = kernel;

	////////////////////////////////////////
	// Datapath

	// Stage 1 multiplies unsigned pixel by signed weight
	always_ff @(posedge clk) begin
		for (int i = 0; i < conv_pkg::KERNEL_SIZE; i++) begin
			prod[i] <= conv_pkg::SUM_WIDTH'($signed({1'b0, pix[i]}) * $signed(wt[i]));
		end
		row_s1 <= win_row;
		col_s1 <= win_col;
	end

	// Stage 2 forms one partial sum per kernel row
	always_ff @(posedge clk) begin
		for (int r = 0; r < conv_pkg::KERNEL_DIM; r++) begin
			row_sum[r] <= prod[conv_pkg::KERNEL_DIM * r]
				+ prod[conv_pkg::KERNEL_DIM * r + 1]
				+ prod[conv_pkg::KERNEL_DIM * r + 2];
		end
		row_s2 <= row_s1;
		col_s2 <= col_s1;
	end

	// Stage 3
	always_ff @(posedge clk) begin
		result.sum <= row_sum[0] + row_sum[1] + row_sum[2];
		result.row <= row_s2;
		result.col <= col_s2;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			valid_s1 <= window_valid;
			valid_s2 <= valid_s1;
			result_valid <= valid_s2;
		end
	end

endmodule

`default_nettype wire

//--- weight_buffer/kernel_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module kernel_fifo (
	input  logic              clk,
	input  logic              reset,
	input  logic              push,
	input  conv_pkg::kernel_t push_data,
	input  logic              pop,
	output conv_pkg::kernel_t pop_data,
	output logic              full,
	output logic              empty
);

	conv_pkg::kernel_t mem [conv_pkg::KFIFO_DEPTH];
	logic [conv_pkg::KFIFO_PTR_WIDTH-1:0] wr_ptr;
	logic [conv_pkg::KFIFO_PTR_WIDTH-1:0] rd_ptr;
	logic [conv_pkg::KFIFO_PTR_WIDTH:0] count;
	logic wr_en;
	logic rd_en;

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Depth is a power of two, pointers wrap by themselves
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry is visible before the pop
	assign pop_data = mem[rd_ptr];
	assign full = (count == conv_pkg::KFIFO_FULL_COUNT);
	assign empty = (count == '0);

	// Weight sender and load controller both have to honour the flags
	assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else $error("kernel_fifo: kernel set pushed while full");
	assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
		else $error("kernel_fifo: pop while empty");

endmodule

`default_nettype wire

//--- weight_buffer/weight_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module weight_buffer (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     weight_valid,
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0] weight_in,
	input  logic                                     load_req,
	output logic                                     load_ack,
	output conv_pkg::kernel_t                        kernel,
	output logic                                     kernel_ready,
	output logic                                     kernel_full
);

	conv_pkg::kernel_t chain;
	conv_pkg::kernel_t fifo_head;
	logic [conv_pkg::TAP_CNT_WIDTH-1:0] tap_count;
	logic set_done;
	logic fifo_empty;
	logic pop;
	logic pop_done;

	////////////////////////////////////////
	// Serial assembly

	// Oldest word drifts down to w0
	always_ff @(posedge clk) begin
		if (weight_valid) begin
			chain.w0 <= chain.w1;
			chain.w1 <= chain.w2;
			chain.w2 <= chain.w3;
			chain.w3 <= chain.w4;
			chain.w4 <= chain.w5;
			chain.w5 <= chain.w6;
			chain.w6 <= chain.w7;
			chain.w7 <= chain.w8;
			chain.w8 <= weight_in;
		end
	end

	// Words modulo 9, set_done marks a full set in the chain
	always_ff @(posedge clk) begin
		if (reset) begin
			tap_count <= '0;
			set_done <= 1'b0;
		end else begin
			set_done <= weight_valid && (tap_count == conv_pkg::LAST_TAP);
			if (weight_valid) begin
				if (tap_count == conv_pkg::LAST_TAP) begin
					tap_count <= '0;
				end else begin
					tap_count <= tap_count + 1'b1;
				end
			end
		end
	end

	kernel_fifo kernel_fifo_i (
		.clk       (clk),
		.reset     (reset),
		.push      (set_done),
		.push_data (chain),
		.pop       (pop),
		.pop_data  (fifo_head),
		.full      (kernel_full),
		.empty     (fifo_empty)
	);

	////////////////////////////////////////
	// Four-phase load responder

	// One pop per exchange, blocked until req drops again
	assign pop = load_req && !load_ack && !pop_done && !fifo_empty;

	always_ff @(posedge clk) begin
		if (pop) begin
			kernel <= fifo_head;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pop_done <= 1'b0;
			load_ack <= 1'b0;
			kernel_ready <= 1'b0;
		end else begin
			pop_done <= pop;
			if (pop_done) begin
				load_ack <= 1'b1;
				kernel_ready <= 1'b1;
			end else if (load_ack && !load_req) begin
				load_ack <= 1'b0;
			end
		end
	end

	// Ack only answers a request that was held through the pop
	assert property (@(posedge clk) disable iff (reset)
		$rose(load_ack) |-> $past(load_req) && $past(load_req, 2))
		else $error("weight_buffer: load_ack rose without load_req");

endmodule

`default_nettype wire

//--- window/line_window.sv
`timescale 1ns/100ps
`default_nettype none

module line_window (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             pixel_valid,
	input  logic [conv_pkg::PIXEL_WIDTH-1:0] pixel_in,
	output logic                             window_valid,
	output conv_pkg::window_t                window,
	output logic [conv_pkg::POS_WIDTH-1:0]   win_row,
	output logic [conv_pkg::POS_WIDTH-1:0]   win_col
);

	logic [conv_pkg::PIXEL_WIDTH-1:0] line_old [conv_pkg::IMG_WIDTH];
	logic [conv_pkg::PIXEL_WIDTH-1:0] line_new [conv_pkg::IMG_WIDTH];
	logic [conv_pkg::PIXEL_WIDTH-1:0] top_pixel;
	logic [conv_pkg::PIXEL_WIDTH-1:0] mid_pixel;
	logic [conv_pkg::POS_WIDTH-1:0] row;
	logic [conv_pkg::POS_WIDTH-1:0] col;
	logic window_done;

	// Pixels of the same column from the two rows above
	assign top_pixel = line_old[col];
	assign mid_pixel = line_new[col];

	// Third row and third column onward completes a window
	assign window_done = pixel_valid
		&& (row >= conv_pkg::POS_WIDTH'(2))
		&& (col >= conv_pkg::POS_WIDTH'(2));

	////////////////////////////////////////
	// Line memories and 3x3 shift window

	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			line_old[col] <= mid_pixel;
			line_new[col] <= pixel_in;
		end
	end

	// New column enters on the right
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			window.p0 <= window.p1;
			window.p1 <= window.p2;
			window.p2 <= top_pixel;
			window.p3 <= window.p4;
			window.p4 <= window.p5;
			window.p5 <= mid_pixel;
			window.p6 <= window.p7;
			window.p7 <= window.p8;
			window.p8 <= pixel_in;
		end
	end

	////////////////////////////////////////
	// Position tracking

	always_ff @(posedge clk) begin
		if (reset) begin
			row <= '0;
			col <= '0;
			window_valid <= 1'b0;
		end else begin
			window_valid <= window_done;
			if (pixel_valid) begin
				if (col == conv_pkg::LAST_COL) begin
					col <= '0;
					// Wrap to row 0 at frame end
					row <= (row == conv_pkg::LAST_ROW) ? '0 : row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// Centre of the window sits one up and one left
	always_ff @(posedge clk) begin
		if (window_done) begin
			win_row <= row - 1'b1;
			win_col <= col - 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		col <= conv_pkg::LAST_COL && row <= conv_pkg::LAST_ROW)
		else $error("line_window: position out of range");

endmodule

`default_nettype wire
